// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcodes of the integer subset
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // funct3 values, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // srl / sra
  localparam logic [2:0] F3_OR   = 3'b110;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    opcode_t     opcode;
  } i_fmt_t;

  // one fetched word, read as R or I type by opcode
  typedef union packed {
    r_fmt_t      r;
    i_fmt_t      i;
    logic [31:0] raw;
  } instr_word_u;

endpackage

// ==== logic/ooo_cfg_pkg.sv ====
package ooo_cfg_pkg;

  // reorder buffer depth, keep a power of two
  localparam int ROB_SIZE = 8;

  // entries in the single alu station
  localparam int RS_DEPTH = 4;

  // architectural integer registers
  localparam int NUM_REGS = 32;

  localparam int TAG_W = $clog2(ROB_SIZE);

  // names one reorder buffer entry
  typedef logic [TAG_W-1:0] rob_tag_t;

endpackage

// ==== logic/dispatch_if.sv ====
`timescale 1ns/100ps

interface dispatch_if;
  import rv_isa_pkg::*;
  import ooo_cfg_pkg::*;

  logic     valid;
  logic     ready;
  alu_op_t  op;
  xlen_t    vj;     // operand values
  xlen_t    vk;
  rob_tag_t qj;     // producer tags while not ready
  rob_tag_t qk;
  logic     j_rdy;
  logic     k_rdy;
  rob_tag_t tag;    // own reorder buffer slot

  modport decode (
    output valid, op, vj, vk, qj, qk, j_rdy, k_rdy, tag,
    input  ready
  );

  modport station (
    input  valid, op, vj, vk, qj, qk, j_rdy, k_rdy, tag,
    output ready
  );

endinterface

// ==== logic/instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
  input  rv_isa_pkg::instr_word_u i_instr,
  input  logic                    i_instr_valid,
  output logic                    o_instr_ready,
  output rv_isa_pkg::reg_addr_t   o_rs1,
  output rv_isa_pkg::reg_addr_t   o_rs2,
  input  rv_isa_pkg::xlen_t       i_rf_val1,
  input  rv_isa_pkg::xlen_t       i_rf_val2,
  input  logic                    i_rf_busy1,
  input  logic                    i_rf_busy2,
  input  ooo_cfg_pkg::rob_tag_t   i_rf_tag1,
  input  ooo_cfg_pkg::rob_tag_t   i_rf_tag2,
  output ooo_cfg_pkg::rob_tag_t   o_rob_q1,
  output ooo_cfg_pkg::rob_tag_t   o_rob_q2,
  input  rv_isa_pkg::xlen_t       i_rob_val1,
  input  rv_isa_pkg::xlen_t       i_rob_val2,
  input  logic                    i_rob_done1,
  input  logic                    i_rob_done2,
  input  logic                    i_rob_space,
  input  ooo_cfg_pkg::rob_tag_t   i_alloc_tag,
  output logic                    o_alloc,
  output rv_isa_pkg::reg_addr_t   o_rd,
  dispatch_if.decode              dsp
);
  import rv_isa_pkg::*;

  logic  is_imm;
  xlen_t imm_sext;

  assign is_imm   = (i_instr.i.opcode == OPC_OP_IMM);
  assign imm_sext = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};

  assign o_rs1 = i_instr.r.rs1;
  assign o_rs2 = i_instr.r.rs2;  // immediate bits on op-imm, result unused
  assign o_rd  = i_instr.r.rd;

  // funct7[5] picks sub and sra, sub only exists as a register op
  always_comb begin
    case (i_instr.r.funct3)
      F3_ADD:  dsp.op = (!is_imm && i_instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
      F3_SLL:  dsp.op = ALU_SLL;
      F3_SLT:  dsp.op = ALU_SLT;
      F3_SLTU: dsp.op = ALU_SLTU;
      F3_XOR:  dsp.op = ALU_XOR;
      F3_SR:   dsp.op = i_instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
      F3_OR:   dsp.op = ALU_OR;
      default: dsp.op = ALU_AND;
    endcase
  end

  // register file if idle, else the rob value once done, else wait on the tag
  assign o_rob_q1 = i_rf_tag1;
  assign o_rob_q2 = i_rf_tag2;
  assign dsp.qj   = i_rf_tag1;
  assign dsp.qk   = i_rf_tag2;

  always_comb begin
    dsp.j_rdy = !i_rf_busy1 || i_rob_done1;
    dsp.vj    = i_rf_busy1 ? i_rob_val1 : i_rf_val1;
    if (is_imm) begin
      dsp.k_rdy = 1'b1;
      dsp.vk    = imm_sext;
    end else begin
      dsp.k_rdy = !i_rf_busy2 || i_rob_done2;
      dsp.vk    = i_rf_busy2 ? i_rob_val2 : i_rf_val2;
    end
  end

  assign dsp.valid     = i_instr_valid && i_rob_space;
  assign dsp.tag       = i_alloc_tag;
  assign o_instr_ready = i_rob_space && dsp.ready;
  assign o_alloc       = dsp.valid && dsp.ready;

  // the source only offers op / op-imm words
  always_comb begin
    if (o_alloc) begin
      assert (i_instr.r.opcode inside {OPC_OP, OPC_OP_IMM})
        else $error("illegal opcode accepted, word %h", i_instr.raw);
    end
  end

endmodule

// ==== logic/rename_regfile.sv ====
`timescale 1ns/100ps

module rename_regfile (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  rv_isa_pkg::reg_addr_t i_rs1,
  input  rv_isa_pkg::reg_addr_t i_rs2,
  output rv_isa_pkg::xlen_t     o_val1,
  output rv_isa_pkg::xlen_t     o_val2,
  output logic                  o_busy1,
  output logic                  o_busy2,
  output ooo_cfg_pkg::rob_tag_t o_tag1,
  output ooo_cfg_pkg::rob_tag_t o_tag2,
  input  logic                  i_alloc,
  input  rv_isa_pkg::reg_addr_t i_alloc_rd,
  input  ooo_cfg_pkg::rob_tag_t i_alloc_tag,
  input  logic                  i_commit,
  input  rv_isa_pkg::reg_addr_t i_commit_rd,
  input  ooo_cfg_pkg::rob_tag_t i_commit_tag,
  input  rv_isa_pkg::xlen_t     i_commit_value
);
  import rv_isa_pkg::*;
  import ooo_cfg_pkg::*;

  xlen_t               regs [NUM_REGS];
  logic [NUM_REGS-1:0] busy;
  rob_tag_t            tags [NUM_REGS];  // youngest producer per register

  // x0 is zeroed at reset and never written or marked busy
  assign o_val1  = regs[i_rs1];
  assign o_val2  = regs[i_rs2];
  assign o_busy1 = busy[i_rs1];
  assign o_busy2 = busy[i_rs2];
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy <= '0;
      for (int r = 0; r < NUM_REGS; r++) begin
        regs[r] <= '0;  // architectural state starts at zero
      end
    end else begin
      if (i_commit && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // a newer rename of the same register stays busy
        if (tags[i_commit_rd] == i_commit_tag) begin
          busy[i_commit_rd] <= 1'b0;
        end
      end
      // rename wins over a same-cycle commit to that register
      if (i_alloc && i_alloc_rd != '0) begin
        busy[i_alloc_rd] <= 1'b1;
        tags[i_alloc_rd] <= i_alloc_tag;
      end
    end
  end

endmodule

// ==== logic/reservation_station.sv ====
`timescale 1ns/100ps

module reservation_station (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  dispatch_if.station           dsp,
  input  logic                  i_cdb_valid,
  input  ooo_cfg_pkg::rob_tag_t i_cdb_tag,
  input  rv_isa_pkg::xlen_t     i_cdb_value,
  input  logic                  i_alu_ready,
  output logic                  o_issue_valid,
  output rv_isa_pkg::alu_op_t   o_issue_op,
  output rv_isa_pkg::xlen_t     o_issue_a,
  output rv_isa_pkg::xlen_t     o_issue_b,
  output ooo_cfg_pkg::rob_tag_t o_issue_tag
);
  import rv_isa_pkg::*;
  import ooo_cfg_pkg::*;

  logic [RS_DEPTH-1:0] e_vld;
  logic [RS_DEPTH-1:0] e_jr;
  logic [RS_DEPTH-1:0] e_kr;
  alu_op_t             e_op  [RS_DEPTH];
  xlen_t               e_vj  [RS_DEPTH];
  xlen_t               e_vk  [RS_DEPTH];
  rob_tag_t            e_qj  [RS_DEPTH];
  rob_tag_t            e_qk  [RS_DEPTH];
  rob_tag_t            e_tag [RS_DEPTH];
  logic [RS_DEPTH-1:0] older [RS_DEPTH];  // bit j set when slot j arrived before slot i

  logic [RS_DEPTH-1:0] rdy;
  logic [RS_DEPTH-1:0] pick;
  logic [RS_DEPTH-1:0] wr_oh;
  logic                wr_fire;

  assign rdy = e_vld & e_jr & e_kr;

  // oldest ready entry wins so younger ready work can pass stalled ones
  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      pick[i] = rdy[i] && !(|(older[i] & rdy));
    end
  end

  always_comb begin
    o_issue_op  = ALU_ADD;
    o_issue_a   = '0;
    o_issue_b   = '0;
    o_issue_tag = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (pick[i]) begin
        o_issue_op  = e_op[i];
        o_issue_a   = e_vj[i];
        o_issue_b   = e_vk[i];
        o_issue_tag = e_tag[i];
      end
    end
  end

  assign o_issue_valid = (|pick) && i_alu_ready;

  assign wr_oh     = ~e_vld & (e_vld + RS_DEPTH'(1));  // lowest free slot
  assign dsp.ready = ~&e_vld;
  assign wr_fire   = dsp.valid && dsp.ready;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      e_vld <= '0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (o_issue_valid && pick[i]) begin
          e_vld[i] <= 1'b0;
        end
        if (i_cdb_valid && !e_jr[i] && e_qj[i] == i_cdb_tag) begin  // snoop bus
          e_jr[i] <= 1'b1;
          e_vj[i] <= i_cdb_value;
        end
        if (i_cdb_valid && !e_kr[i] && e_qk[i] == i_cdb_tag) begin
          e_kr[i] <= 1'b1;
          e_vk[i] <= i_cdb_value;
        end
        if (wr_fire) begin
          older[i] <= older[i] & ~wr_oh;  // newcomer is younger than all
        end
        if (wr_fire && wr_oh[i]) begin
          e_vld[i] <= 1'b1;
          e_op[i]  <= dsp.op;
          e_vj[i]  <= dsp.vj;
          e_vk[i]  <= dsp.vk;
          e_qj[i]  <= dsp.qj;
          e_qk[i]  <= dsp.qk;
          e_jr[i]  <= dsp.j_rdy;
          e_kr[i]  <= dsp.k_rdy;
          e_tag[i] <= dsp.tag;
          older[i] <= e_vld;
        end
      end
    end
  end

  // a transfer lands in exactly one slot that was free
  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    wr_fire |-> $onehot(wr_oh) && ((wr_oh & e_vld) == '0));

endmodule

// ==== logic/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  logic                  i_valid,
  input  rv_isa_pkg::alu_op_t   i_op,
  input  rv_isa_pkg::xlen_t     i_a,
  input  rv_isa_pkg::xlen_t     i_b,
  input  ooo_cfg_pkg::rob_tag_t i_tag,
  output logic                  o_ready,
  output logic                  o_valid,
  output ooo_cfg_pkg::rob_tag_t o_tag,
  output rv_isa_pkg::xlen_t     o_result
);
  import rv_isa_pkg::*;

  xlen_t res;

  always_comb begin
    case (i_op)
      ALU_ADD:  res = i_a + i_b;
      ALU_SUB:  res = i_a - i_b;
      ALU_SLL:  res = i_a << i_b[4:0];
      ALU_SLT:  res = {31'b0, $signed(i_a) < $signed(i_b)};
      ALU_SLTU: res = {31'b0, i_a < i_b};
      ALU_XOR:  res = i_a ^ i_b;
      ALU_SRL:  res = i_a >> i_b[4:0];
      ALU_SRA:  res = $signed(i_a) >>> i_b[4:0];
      ALU_OR:   res = i_a | i_b;
      default:  res = i_a & i_b;
    endcase
  end

  assign o_ready = 1'b1;  // single cycle, takes one op every clock

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
    o_tag    <= i_tag;
    o_result <= res;
  end

endmodule

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/100ps

module reorder_buffer (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  logic                  i_alloc,
  input  rv_isa_pkg::reg_addr_t i_alloc_rd,
  output ooo_cfg_pkg::rob_tag_t o_alloc_tag,
  output logic                  o_space,
  input  ooo_cfg_pkg::rob_tag_t i_q1,
  input  ooo_cfg_pkg::rob_tag_t i_q2,
  output rv_isa_pkg::xlen_t     o_val1,
  output rv_isa_pkg::xlen_t     o_val2,
  output logic                  o_done1,
  output logic                  o_done2,
  input  logic                  i_fu_valid,
  input  ooo_cfg_pkg::rob_tag_t i_fu_tag,
  input  rv_isa_pkg::xlen_t     i_fu_result,
  output logic                  o_cdb_valid,
  output ooo_cfg_pkg::rob_tag_t o_cdb_tag,
  output rv_isa_pkg::xlen_t     o_cdb_value,
  output logic                  o_commit_valid,
  output rv_isa_pkg::reg_addr_t o_commit_rd,
  output ooo_cfg_pkg::rob_tag_t o_commit_tag,
  output rv_isa_pkg::xlen_t     o_commit_value
);
  import rv_isa_pkg::*;
  import ooo_cfg_pkg::*;

  reg_addr_t           ent_rd  [ROB_SIZE];
  xlen_t               ent_val [ROB_SIZE];
  logic [ROB_SIZE-1:0] ent_done;
  rob_tag_t            head;
  rob_tag_t            tail;
  logic [TAG_W:0]      count;

  assign o_space     = !count[TAG_W];  // msb only set when all entries live
  assign o_alloc_tag = tail;

  // operand lookups for decode
  assign o_val1  = ent_val[i_q1];
  assign o_val2  = ent_val[i_q2];
  assign o_done1 = ent_done[i_q1];
  assign o_done2 = ent_done[i_q2];

  // retire the head as soon as it's done, no back-pressure
  assign o_commit_valid = (count != '0) && ent_done[head];
  assign o_commit_rd    = ent_rd[head];
  assign o_commit_tag   = head;
  assign o_commit_value = ent_val[head];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head        <= '0;
      tail        <= '0;
      count       <= '0;
      ent_done    <= '0;
      o_cdb_valid <= 1'b0;
    end else begin
      o_cdb_valid <= i_fu_valid;  // bus lags the alu by one clock
      if (i_fu_valid) begin
        ent_done[i_fu_tag] <= 1'b1;
      end
      if (i_alloc) begin
        ent_done[tail] <= 1'b0;
        tail           <= tail + rob_tag_t'(1);
      end
      if (o_commit_valid) begin
        head <= head + rob_tag_t'(1);
      end
      count <= count + (TAG_W+1)'(i_alloc) - (TAG_W+1)'(o_commit_valid);
    end
  end

  // payload side
  always_ff @(posedge clk_100mhz) begin
    o_cdb_tag   <= i_fu_tag;
    o_cdb_value <= i_fu_result;
    if (i_fu_valid) begin
      ent_val[i_fu_tag] <= i_fu_result;
    end
    if (i_alloc) begin
      ent_rd[tail] <= i_alloc_rd;
    end
  end

  // a finished op must belong to a live entry that has no result yet
  assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_fu_valid |-> ({1'b0, rob_tag_t'(i_fu_tag - head)} < count) && !ent_done[i_fu_tag]);

endmodule

// ==== logic/ooo_core.sv ====
`timescale 1ns/100ps

module ooo_core (
  input  logic                  clk_100mhz,
  input  logic                  sys_rst,
  input  rv_isa_pkg::xlen_t     i_instr,
  input  logic                  i_instr_valid,
  output logic                  o_instr_ready,
  output logic                  o_commit_valid,
  output rv_isa_pkg::reg_addr_t o_commit_rd,
  output rv_isa_pkg::xlen_t     o_commit_value
);

  // decode <-> register file
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::xlen_t     rf_val1;
  rv_isa_pkg::xlen_t     rf_val2;
  logic                  rf_busy1;
  logic                  rf_busy2;
  ooo_cfg_pkg::rob_tag_t rf_tag1;
  ooo_cfg_pkg::rob_tag_t rf_tag2;

  // decode <-> reorder buffer
  ooo_cfg_pkg::rob_tag_t rob_q1;
  ooo_cfg_pkg::rob_tag_t rob_q2;
  rv_isa_pkg::xlen_t     rob_val1;
  rv_isa_pkg::xlen_t     rob_val2;
  logic                  rob_done1;
  logic                  rob_done2;
  logic                  rob_space;
  ooo_cfg_pkg::rob_tag_t alloc_tag;
  logic                  alloc;

  // station -> alu -> reorder buffer
  logic                  iss_valid;
  rv_isa_pkg::alu_op_t   iss_op;
  rv_isa_pkg::xlen_t     iss_a;
  rv_isa_pkg::xlen_t     iss_b;
  ooo_cfg_pkg::rob_tag_t iss_tag;
  logic                  alu_ready;
  logic                  alu_valid;
  ooo_cfg_pkg::rob_tag_t alu_tag;
  rv_isa_pkg::xlen_t     alu_result;

  // common data bus and commit
  logic                  cdb_valid;
  ooo_cfg_pkg::rob_tag_t cdb_tag;
  rv_isa_pkg::xlen_t     cdb_value;
  ooo_cfg_pkg::rob_tag_t commit_tag;

  dispatch_if dsp ();

  instr_decode u_decode (
    .i_instr       (i_instr),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .o_rs1         (rs1),
    .o_rs2         (rs2),
    .i_rf_val1     (rf_val1),
    .i_rf_val2     (rf_val2),
    .i_rf_busy1    (rf_busy1),
    .i_rf_busy2    (rf_busy2),
    .i_rf_tag1     (rf_tag1),
    .i_rf_tag2     (rf_tag2),
    .o_rob_q1      (rob_q1),
    .o_rob_q2      (rob_q2),
    .i_rob_val1    (rob_val1),
    .i_rob_val2    (rob_val2),
    .i_rob_done1   (rob_done1),
    .i_rob_done2   (rob_done2),
    .i_rob_space   (rob_space),
    .i_alloc_tag   (alloc_tag),
    .o_alloc       (alloc),
    .o_rd          (rd),
    .dsp           (dsp.decode)
  );

  rename_regfile u_regfile (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_rs1          (rs1),
    .i_rs2          (rs2),
    .o_val1         (rf_val1),
    .o_val2         (rf_val2),
    .o_busy1        (rf_busy1),
    .o_busy2        (rf_busy2),
    .o_tag1         (rf_tag1),
    .o_tag2         (rf_tag2),
    .i_alloc        (alloc),
    .i_alloc_rd     (rd),
    .i_alloc_tag    (alloc_tag),
    .i_commit       (o_commit_valid),
    .i_commit_rd    (o_commit_rd),
    .i_commit_tag   (commit_tag),
    .i_commit_value (o_commit_value)
  );

  reservation_station u_rs (
    .clk_100mhz    (clk_100mhz),
    .sys_rst       (sys_rst),
    .dsp           (dsp.station),
    .i_cdb_valid   (cdb_valid),
    .i_cdb_tag     (cdb_tag),
    .i_cdb_value   (cdb_value),
    .i_alu_ready   (alu_ready),
    .o_issue_valid (iss_valid),
    .o_issue_op    (iss_op),
    .o_issue_a     (iss_a),
    .o_issue_b     (iss_b),
    .o_issue_tag   (iss_tag)
  );

  int_alu u_alu (
    .clk_100mhz (clk_100mhz),
    .sys_rst    (sys_rst),
    .i_valid    (iss_valid),
    .i_op       (iss_op),
    .i_a        (iss_a),
    .i_b        (iss_b),
    .i_tag      (iss_tag),
    .o_ready    (alu_ready),
    .o_valid    (alu_valid),
    .o_tag      (alu_tag),
    .o_result   (alu_result)
  );

  reorder_buffer u_rob (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_alloc        (alloc),
    .i_alloc_rd     (rd),
    .o_alloc_tag    (alloc_tag),
    .o_space        (rob_space),
    .i_q1           (rob_q1),
    .i_q2           (rob_q2),
    .o_val1         (rob_val1),
    .o_val2         (rob_val2),
    .o_done1        (rob_done1),
    .o_done2        (rob_done2),
    .i_fu_valid     (alu_valid),
    .i_fu_tag       (alu_tag),
    .i_fu_result    (alu_result),
    .o_cdb_valid    (cdb_valid),
    .o_cdb_tag      (cdb_tag),
    .o_cdb_value    (cdb_value),
    .o_commit_valid (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_tag   (commit_tag),
    .o_commit_value (o_commit_value)
  );

endmodule

// ==== tb/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// galois lfsr, one step per random bit
function automatic logic lfsr_bit();
  logic out;
  out        = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) begin
    lfsr_state = lfsr_state ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
  end
  return out;
endfunction

function automatic xlen_t rand_bits(input int n);
  xlen_t v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

function automatic xlen_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                input int rd);
  return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
endfunction

function automatic xlen_t enc_i(input int imm, input int rs1, input int f3, input int rd);
  return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
endfunction

// rv32i result of one op / op-imm word
function automatic xlen_t alu_ref(input xlen_t w, input xlen_t a, input xlen_t rs2_val);
  logic               imm_form;
  logic               alt;
  xlen_t              b;
  logic signed [31:0] sa;
  logic signed [31:0] sb;
  imm_form = (w[6:0] == 7'b0010011);
  alt      = w[30];  // sub / sra select
  b        = imm_form ? {{20{w[31]}}, w[31:20]} : rs2_val;
  sa       = a;
  sb       = b;
  case (w[14:12])
    3'd0: return (alt && !imm_form) ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return (sa < sb) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return sa >>> b[4:0];
      end
      return a >> b[4:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// legal op or op-imm word over x0..x7
function automatic xlen_t rand_instr();
  int    f3;
  int    rd;
  int    rs1;
  int    rs2;
  int    alt;
  logic  use_imm;
  xlen_t w;
  use_imm = 1'(rand_bits(1));
  f3      = int'(rand_bits(3));
  rd      = int'(rand_bits(3));
  rs1     = int'(rand_bits(3));
  rs2     = int'(rand_bits(3));
  alt     = int'(rand_bits(1));
  if (!use_imm) begin
    w = enc_r((alt != 0 && (f3 == 0 || f3 == 5)) ? 32 : 0, rs2, rs1, f3, rd);
  end else if (f3 == 1 || f3 == 5) begin
    w = enc_i(((alt != 0 && f3 == 5) ? 32'h400 : 0) | int'(rand_bits(5)), rs1, f3, rd);
  end else begin
    w = enc_i(int'(rand_bits(12)), rs1, f3, rd);
  end
  return w;
endfunction

`endif

// ==== tb/tb_ooo_core.sv ====
`timescale 1ns/100ps

module tb_ooo_core;
  import rv_isa_pkg::*;
  import ooo_cfg_pkg::*;

  localparam int N_FUNC      = 23;
  localparam int N_CHAIN     = 24;
  localparam int N_X0        = 6;
  localparam int N_BURST     = 3 * ROB_SIZE;
  localparam int N_RAND      = 300;
  localparam int CYCLE_LIMIT = 64 * (N_FUNC + N_CHAIN + N_X0 + N_BURST + N_RAND) + 200;

  logic      clk_100mhz;
  logic      sys_rst;
  xlen_t     i_instr;
  logic      i_instr_valid;
  logic      o_instr_ready;
  logic      o_commit_valid;
  reg_addr_t o_commit_rd;
  xlen_t     o_commit_value;

  logic [31:0] lfsr_state;
  xlen_t       shadow [NUM_REGS];  // architectural state in program order
  reg_addr_t   exp_rd_q [$];
  xlen_t       exp_val_q [$];
  xlen_t       prog [$];
  int          sent_count;
  int          commit_count;
  int          err_count;
  int          check_count;
  int          stall_cycles;
  int          test_count;
  int          sent0;
  int          err0;

  `include "tb_ref_model.svh"

  ooo_core i_dut (
    .clk_100mhz     (clk_100mhz),
    .sys_rst        (sys_rst),
    .i_instr        (i_instr),
    .i_instr_valid  (i_instr_valid),
    .o_instr_ready  (o_instr_ready),
    .o_commit_valid (o_commit_valid),
    .o_commit_rd    (o_commit_rd),
    .o_commit_value (o_commit_value)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_100mhz);
      cycles++;
    end
    $display("ERROR: run timed out after %0d cycles, commits stopped", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_eq(input xlen_t got, input xlen_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  task automatic apply_reset();
    sys_rst       = 1'b1;
    i_instr_valid = 1'b0;
    repeat (8) @(negedge clk_100mhz);
    sys_rst = 1'b0;
    for (int r = 0; r < NUM_REGS; r++) begin
      shadow[r] = '0;
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send(input xlen_t word);
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     val;
    i_instr       = word;
    i_instr_valid = 1'b1;
    while (!o_instr_ready) begin  // ready only follows core state
      stall_cycles++;
      @(negedge clk_100mhz);
    end
    rs1 = word[19:15];
    rs2 = word[24:20];
    rd  = word[11:7];
    val = alu_ref(word, shadow[rs1], shadow[rs2]);
    if (rd != 5'd0) begin
      shadow[rd] = val;  // x0 stays zero
    end
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(val);
    sent_count++;
    @(negedge clk_100mhz);
  endtask

  task automatic idle(input int n);
    i_instr_valid = 1'b0;
    repeat (n) @(negedge clk_100mhz);
  endtask

  task automatic run_prog(input int gap_mod);
    foreach (prog[i]) begin
      send(prog[i]);
      if (gap_mod > 0) begin
        idle(i % gap_mod);
      end
    end
  endtask

  task automatic drain();
    i_instr_valid = 1'b0;
    while (commit_count < sent_count) begin
      @(negedge clk_100mhz);
    end
    repeat (4) @(negedge clk_100mhz);  // room for a stray extra commit
  endtask

  task automatic end_test(input string name);
    drain();
    test_count++;
    $display("test %0d %s: %0d instructions, %0d errors", test_count, name,
             sent_count - sent0, err_count - err0);
    sent0 = sent_count;
    err0  = err_count;
  endtask

  // commit checker, outputs are settled at the falling edge
  always @(negedge clk_100mhz) begin
    if (sys_rst) begin
      check_eq(32'(o_commit_valid), 32'd0, "commit valid in reset");
    end else if (o_commit_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("ERROR: commit of x%0d at %0t with no instruction outstanding",
                 o_commit_rd, $time);
        err_count++;
      end else begin
        check_eq(32'(o_commit_rd), 32'(exp_rd_q.pop_front()),
                 $sformatf("commit %0d rd", commit_count));
        check_eq(o_commit_value, exp_val_q.pop_front(),
                 $sformatf("commit %0d value", commit_count));
      end
      commit_count++;
    end
  end

  initial begin
    int stall0;
    $timeformat(-9, 1, " ns", 0);
    i_instr       = '0;
    i_instr_valid = 1'b0;
    sys_rst       = 1'b1;
    lfsr_state    = 32'h6b3d;
    sent_count    = 0;
    commit_count  = 0;
    err_count     = 0;
    check_count   = 0;
    stall_cycles  = 0;
    test_count    = 0;
    sent0         = 0;
    err0          = 0;
    apply_reset();

    // every alu function, r and i forms, sources settled first
    send(enc_i(-1234, 0, 0, 1));
    send(enc_i(1443, 0, 0, 2));
    send(enc_i(7, 0, 0, 3));
    send(enc_i(-8, 0, 0, 4));
    drain();
    send(enc_r(0, 2, 1, 0, 10));   // add
    send(enc_r(32, 2, 1, 0, 11));  // sub
    send(enc_r(0, 3, 2, 1, 12));
    send(enc_r(0, 2, 1, 2, 13));
    send(enc_r(0, 2, 1, 3, 14));
    send(enc_r(0, 2, 1, 4, 15));
    send(enc_r(0, 3, 1, 5, 16));   // srl
    send(enc_r(32, 3, 1, 5, 17));  // sra
    send(enc_r(0, 4, 2, 6, 18));
    send(enc_r(0, 2, 1, 7, 19));
    send(enc_i(100, 1, 0, 20));
    send(enc_i(-5, 1, 2, 21));
    send(enc_i(-1, 2, 3, 22));
    send(enc_i(2047, 1, 4, 23));
    send(enc_i(-256, 2, 6, 24));
    send(enc_i(240, 1, 7, 25));
    send(enc_i(9, 2, 1, 26));
    send(enc_i(4, 1, 5, 27));
    send(enc_i(32'h404, 1, 5, 28));  // srai
    end_test("functions");

    // each word reads the previous rd
    prog.delete();
    prog.push_back(enc_i(3, 0, 0, 5));
    repeat (4) prog.push_back(enc_r(0, 5, 5, 0, 5));
    prog.push_back(enc_r(32, 1, 5, 0, 6));
    prog.push_back(enc_r(0, 5, 6, 4, 6));
    prog.push_back(enc_i(3, 6, 1, 6));
    prog.push_back(enc_r(32, 3, 6, 5, 7));
    prog.push_back(enc_r(0, 6, 7, 6, 7));
    prog.push_back(enc_r(0, 6, 7, 3, 8));
    prog.push_back(enc_r(0, 7, 8, 0, 9));
    run_prog(0);  // back to back, operands come off the bus
    run_prog(4);  // gaps, operands come from the rob
    end_test("chains");

    send(enc_i(55, 0, 0, 0));
    send(enc_r(0, 2, 1, 0, 0));
    send(enc_r(0, 0, 0, 0, 7));    // reads x0 twice
    send(enc_i(9, 0, 0, 8));
    send(enc_r(32, 1, 8, 0, 0));
    send(enc_r(0, 8, 0, 6, 9));
    end_test("x0 writes");

    // dependent burst, valid held high across stalls
    prog.delete();
    for (int i = 0; i < N_BURST; i++) begin
      if (i % 2 == 0) begin
        prog.push_back(enc_r(0, 3, 10, 0, 10));
      end else begin
        prog.push_back(enc_r(0, 10, 11, 4, 11));
      end
    end
    stall0 = stall_cycles;
    run_prog(0);
    if (stall_cycles == stall0) begin
      $display("ERROR: burst of %0d never saw o_instr_ready low", N_BURST);
      err_count++;
    end
    end_test("back-pressure");

    apply_reset();
    repeat (N_RAND) begin
      send(rand_instr());
      if (rand_bits(2) == 32'd0) begin
        idle(1);
      end
    end
    end_test("random");

    test_count++;
    if (commit_count != sent_count || exp_rd_q.size() != 0) begin
      $display("ERROR: %0d instructions accepted but %0d committed", sent_count, commit_count);
      err_count++;
    end
    $display("test %0d order: %0d accepted, %0d committed", test_count, sent_count,
             commit_count);

    $display("summary: %0d tests, %0d instructions, %0d checks, %0d errors", test_count,
             sent_count, check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+tb
logic/rv_isa_pkg.sv
logic/ooo_cfg_pkg.sv
logic/dispatch_if.sv
logic/instr_decode.sv
logic/rename_regfile.sv
logic/reservation_station.sv
logic/int_alu.sv
logic/reorder_buffer.sv
logic/ooo_core.sv
tb/tb_ooo_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_ooo_core -f project.f -o tb_ooo_core

./obj_dir/tb_ooo_core | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
